//--- bnn_conv_assertions.sv
// concurrent port checks for the convolution engine, bound into bnn_conv_top by the testbench
module bnn_conv_assertions (
	input logic clk,
	input logic reset_b,
	input logic dut_busy,
	input logic dut_sram_write_enable,
	input bnn_conv_pkg::mem_word_t dut_sram_write_data
);
	timeunit 1ns;
	timeprecision 1ns;

	// writes only inside a job
	write_in_job: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy)
		else $error("write enable high while dut_busy is low");

	// written word fully defined
	write_data_known: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> !$isunknown(dut_sram_write_data))
		else $error("write data unknown while write enable is high");

	// busy cleared by the asynchronous reset
	busy_in_reset: assert property (@(posedge clk)
		!reset_b |-> !dut_busy)
		else $error("dut_busy high during reset");

endmodule

//--- bnn_conv_pkg.sv
// shared widths, constants, reader states and pipeline structs for the binary convolution engine
package bnn_conv_pkg;

	// sram address and data word
	typedef logic [11:0] mem_addr_t;
	typedef logic [15:0] mem_word_t;
	// column or bit position inside one image row
	typedef logic [3:0] col_idx_t;
	// 3x3 kernel, bit 3*r+k is row r column k
	typedef logic [8:0] kernel_t;

	// row-count word that ends a job
	localparam mem_word_t end_marker = 16'h00FF;
	// weight word that holds the kernel
	localparam mem_addr_t weight_addr = 12'h001;
	// window is fixed at 3x3
	localparam int kernel_dim = 3;
	// five or more mismatches out of nine gives a 0
	localparam int majority_limit = 5;
	// last column out of the reader to its write strobe
	localparam int drain_cycles = 3;

	typedef enum logic [3:0] {
		idle,
		read_rows,
		read_cols,
		read_weights,
		load_row0,
		load_row1,
		load_row2,
		sweep,
		fetch_row,
		shift_rows,
		drain
	} reader_state_t;

	// one window column, bits[0] is window row 0
	typedef struct packed {
		logic valid;
		logic [kernel_dim-1:0] bits;
		col_idx_t col;
		logic last;
	} conv_column_t;

	// one output bit with its position in the row word
	typedef struct packed {
		logic valid;
		logic value;
		col_idx_t idx;
		logic last;
	} conv_result_t;

endpackage

//--- bnn_conv_top.sv
// top level of the convolution engine, connects reader, window array and packer to the srams
module bnn_conv_top (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	output logic dut_busy,
	output bnn_conv_pkg::mem_addr_t dut_sram_read_address,
	input bnn_conv_pkg::mem_word_t sram_dut_read_data,
	output bnn_conv_pkg::mem_addr_t dut_wmem_read_address,
	input bnn_conv_pkg::mem_word_t wmem_dut_read_data,
	output bnn_conv_pkg::mem_addr_t dut_sram_write_address,
	output bnn_conv_pkg::mem_word_t dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// reader to window array
	bnn_conv_pkg::conv_column_t column;
	bnn_conv_pkg::kernel_t kernel;
	logic kernel_load;
	// reader to packer
	logic job_start;
	// window array to packer
	bnn_conv_pkg::conv_result_t result;

	conv_reader u_reader (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.sram_dut_read_data(sram_dut_read_data),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address),
		.dut_busy(dut_busy),
		.job_start(job_start),
		.kernel_load(kernel_load),
		.kernel(kernel),
		.column(column)
	);

	conv_window_array u_window (
		.clk(clk),
		.reset_b(reset_b),
		.kernel_load(kernel_load),
		.kernel(kernel),
		.column(column),
		.result(result)
	);

	row_packer u_packer (
		.clk(clk),
		.reset_b(reset_b),
		.job_start(job_start),
		.result(result),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

endmodule

//--- bnn_conv_trace.txt
# i addr data loads the input sram, w addr data loads the weight sram, values in hex
# r starts a job, the e addr data lines after it are its expected writes in order
# one 3x3 image, kernels around the five-mismatch limit
i 000 0003
i 001 0003
i 002 0003
i 003 0001
i 004 0000
i 005 00FF
w 001 000B
r
e 000 0001
w 001 00C0
r
e 000 0000
w 001 0040
r
e 000 0001
# 5x16 image, kernel rows 0 and 2 set
i 000 0005
i 001 0010
i 002 FFFF
i 003 00FF
i 004 0F0F
i 005 3333
i 006 5555
i 007 00FF
w 001 01C7
r
e 000 3FC7
e 001 107D
e 002 0747
# end marker only, no writes
i 000 00FF
r
# 4x5 image then 3x16 image in one job, only the middle kernel row set
i 000 0004
i 001 0005
i 002 001F
i 003 0007
i 004 001A
i 005 000C
i 006 0003
i 007 0010
i 008 0F0F
i 009 3333
i 00A 5555
i 00B 00FF
w 001 0038
r
e 000 0001
e 001 0004
e 002 38B8

//--- conv_reader.sv
// input side of the engine, walks the input sram image by image and streams window columns
module conv_reader (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input bnn_conv_pkg::mem_word_t sram_dut_read_data,
	input bnn_conv_pkg::mem_word_t wmem_dut_read_data,
	output bnn_conv_pkg::mem_addr_t dut_sram_read_address,
	output bnn_conv_pkg::mem_addr_t dut_wmem_read_address,
	output logic dut_busy,
	output logic job_start,
	output logic kernel_load,
	output bnn_conv_pkg::kernel_t kernel,
	output bnn_conv_pkg::conv_column_t column
);

	bnn_conv_pkg::reader_state_t state;
	// three image rows under the window, row0 on top
	bnn_conv_pkg::mem_word_t row0;
	bnn_conv_pkg::mem_word_t row1;
	bnn_conv_pkg::mem_word_t row2;
	// row fetched in the gap between two sweeps
	bnn_conv_pkg::mem_word_t next_row;
	// window rows still to sweep in this image
	bnn_conv_pkg::col_idx_t rows_left;
	// cols-1 of the current image
	bnn_conv_pkg::col_idx_t last_col;
	bnn_conv_pkg::col_idx_t col_cnt;
	logic [1:0] drain_cnt;

	// FSM and counters
	// the read address always runs one word ahead of the state that consumes it
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= bnn_conv_pkg::idle;
			dut_busy <= 1'b0;
			dut_sram_read_address <= '0;
			dut_wmem_read_address <= '0;
			rows_left <= '0;
			last_col <= '0;
			col_cnt <= '0;
			drain_cnt <= '0;
		end else begin
			unique case (state)
				bnn_conv_pkg::idle: begin
					// run is only looked at here, pulses while busy are dropped
					if (dut_run) begin
						state <= bnn_conv_pkg::read_rows;
						dut_busy <= 1'b1;
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						dut_wmem_read_address <= bnn_conv_pkg::weight_addr;
					end
				end
				bnn_conv_pkg::read_rows: begin
					if (sram_dut_read_data == bnn_conv_pkg::end_marker) begin
						state <= bnn_conv_pkg::drain;
						drain_cnt <= 2'(bnn_conv_pkg::drain_cycles - 1);
					end else begin
						// rows-2 window rows, 16 rows wraps to 14 as wanted
						rows_left <= bnn_conv_pkg::col_idx_t'(sram_dut_read_data)
							- bnn_conv_pkg::col_idx_t'(bnn_conv_pkg::kernel_dim - 1);
						state <= bnn_conv_pkg::read_cols;
					end
				end
				bnn_conv_pkg::read_cols: begin
					last_col <= bnn_conv_pkg::col_idx_t'(sram_dut_read_data)
						- bnn_conv_pkg::col_idx_t'(1);
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= bnn_conv_pkg::read_weights;
				end
				bnn_conv_pkg::read_weights: begin
					// kernel goes out on kernel_load this cycle
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= bnn_conv_pkg::load_row0;
				end
				bnn_conv_pkg::load_row0: begin
					row0 <= sram_dut_read_data;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= bnn_conv_pkg::load_row1;
				end
				bnn_conv_pkg::load_row1: begin
					row1 <= sram_dut_read_data;
					// now points at the fourth row, or the next image
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= bnn_conv_pkg::load_row2;
				end
				bnn_conv_pkg::load_row2: begin
					row2 <= sram_dut_read_data;
					col_cnt <= '0;
					state <= bnn_conv_pkg::sweep;
				end
				bnn_conv_pkg::sweep: begin
					col_cnt <= col_cnt + 1'b1;
					if (col_cnt == last_col) begin
						col_cnt <= '0;
						rows_left <= rows_left - 1'b1;
						if (rows_left == bnn_conv_pkg::col_idx_t'(1)) begin
							// address already sits on the next row-count word
							dut_sram_read_address <= dut_sram_read_address + 1'b1;
							state <= bnn_conv_pkg::read_rows;
						end else begin
							state <= bnn_conv_pkg::fetch_row;
						end
					end
				end
				bnn_conv_pkg::fetch_row: begin
					next_row <= sram_dut_read_data;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= bnn_conv_pkg::shift_rows;
				end
				bnn_conv_pkg::shift_rows: begin
					// move the window one image row down
					row0 <= row1;
					row1 <= row2;
					row2 <= next_row;
					state <= bnn_conv_pkg::sweep;
				end
				bnn_conv_pkg::drain: begin
					// busy drops three cycles after the marker, after the last write
					drain_cnt <= drain_cnt - 1'b1;
					if (drain_cnt == 2'd1) begin
						state <= bnn_conv_pkg::idle;
						dut_busy <= 1'b0;
						dut_sram_read_address <= '0;
					end
				end
				default: begin
					state <= bnn_conv_pkg::idle;
				end
			endcase
		end
	end

	assign job_start = (state == bnn_conv_pkg::idle) && dut_run;

	// kernel word arrives while in read_weights
	assign kernel_load = (state == bnn_conv_pkg::read_weights);
	assign kernel = bnn_conv_pkg::kernel_t'(wmem_dut_read_data);

	// one column per sweep cycle
	assign column.valid = (state == bnn_conv_pkg::sweep);
	assign column.bits = {row2[col_cnt], row1[col_cnt], row0[col_cnt]};
	assign column.col = col_cnt;
	assign column.last = (col_cnt == last_col);

endmodule

//--- conv_window_array.sv
// processing stage, keeps the kernel and a 3x3 window and produces one pipelined majority bit
module conv_window_array (
	input logic clk,
	input logic reset_b,
	input logic kernel_load,
	input bnn_conv_pkg::kernel_t kernel,
	input bnn_conv_pkg::conv_column_t column,
	output bnn_conv_pkg::conv_result_t result
);

	bnn_conv_pkg::kernel_t weights;
	// two earlier columns, the incoming one is the right edge
	logic [bnn_conv_pkg::kernel_dim-1:0] win_left;
	logic [bnn_conv_pkg::kernel_dim-1:0] win_mid;
	bnn_conv_pkg::kernel_t window;
	bnn_conv_pkg::kernel_t agree;
	// stage one, mismatches per kernel row
	logic [1:0] row_miss [bnn_conv_pkg::kernel_dim];
	logic s1_valid;
	bnn_conv_pkg::col_idx_t s1_idx;
	logic s1_last;
	logic [3:0] miss_sum;
	// stage two
	logic res_valid;
	logic res_value;
	bnn_conv_pkg::col_idx_t res_idx;
	logic res_last;

	// window laid out like the kernel, bit 3*r+k
	always_comb begin
		for (int r = 0; r < bnn_conv_pkg::kernel_dim; r++) begin
			window[bnn_conv_pkg::kernel_dim*r] = win_left[r];
			window[bnn_conv_pkg::kernel_dim*r + 1] = win_mid[r];
			window[bnn_conv_pkg::kernel_dim*r + 2] = column.bits[r];
		end
		agree = ~(window ^ weights);
	end

	// total mismatches over the nine pairs, at most 9
	assign miss_sum = {2'b00, row_miss[0]} + {2'b00, row_miss[1]} + {2'b00, row_miss[2]};

	// valid flags
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			// first full window once column 2 arrives
			s1_valid <= column.valid
				&& (column.col >= bnn_conv_pkg::col_idx_t'(bnn_conv_pkg::kernel_dim - 1));
			res_valid <= s1_valid;
		end
	end

	// kernel, window and the two pipeline stages
	always_ff @(posedge clk) begin
		if (kernel_load)
			weights <= kernel;
		if (column.valid) begin
			win_left <= win_mid;
			win_mid <= column.bits;
		end
		for (int r = 0; r < bnn_conv_pkg::kernel_dim; r++) begin
			// full adder on the three inverted matches of a row
			row_miss[r] <= {
				(~agree[3*r] & ~agree[3*r+1]) | (~agree[3*r+2] & (~agree[3*r] | ~agree[3*r+1])),
				~(agree[3*r] ^ agree[3*r+1] ^ agree[3*r+2])
			};
		end
		// index of the leftmost window column
		s1_idx <= column.col - bnn_conv_pkg::col_idx_t'(bnn_conv_pkg::kernel_dim - 1);
		s1_last <= column.last;
		res_value <= (miss_sum < 4'(bnn_conv_pkg::majority_limit));
		res_idx <= s1_idx;
		res_last <= s1_last;
	end

	assign result = '{valid: res_valid, value: res_value, idx: res_idx, last: res_last};

endmodule

//--- files.f
bnn_conv_pkg.sv
conv_reader.sv
conv_window_array.sv
row_packer.sv
bnn_conv_top.sv
tb_clock_gen.sv
bnn_conv_assertions.sv
tb_bnn_conv.sv

//--- row_packer.sv
// output stage, gathers result bits into one row word and writes it to the output sram
module row_packer (
	input logic clk,
	input logic reset_b,
	input logic job_start,
	input bnn_conv_pkg::conv_result_t result,
	output bnn_conv_pkg::mem_addr_t dut_sram_write_address,
	output bnn_conv_pkg::mem_word_t dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// bits of the row being built, unused high bits stay 0
	bnn_conv_pkg::mem_word_t acc;
	bnn_conv_pkg::mem_word_t row_next;
	// next free output address, runs on across images
	bnn_conv_pkg::mem_addr_t wr_cnt;
	logic row_done;

	assign row_done = result.valid && result.last;

	// accumulator with the current bit merged in
	always_comb begin
		row_next = acc;
		if (result.valid)
			row_next[result.idx] = result.value;
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc <= '0;
			wr_cnt <= '0;
			dut_sram_write_address <= '0;
			dut_sram_write_enable <= 1'b0;
		end else begin
			// one-cycle strobe right after the last bit of a row
			dut_sram_write_enable <= row_done;
			if (job_start) begin
				acc <= '0;
				wr_cnt <= '0;
			end else if (row_done) begin
				acc <= '0;
				wr_cnt <= wr_cnt + 1'b1;
				dut_sram_write_address <= wr_cnt;
			end else if (result.valid) begin
				acc <= row_next;
			end
		end
	end

	// finished word, only meaningful with the strobe
	always_ff @(posedge clk) begin
		if (row_done)
			dut_sram_write_data <= row_next;
	end

endmodule

//--- run.sh
#!/bin/bash
# build the convolution engine testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_bnn_conv -o sim_bnn_conv

./obj_dir/sim_bnn_conv 2>&1 | tee sim.log

if grep -q ">>> PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- tb_bnn_conv.sv
// top-level testbench that replays bnn_conv_trace.txt through the convolution engine and checks every sram write
module tb_bnn_conv;
	timeunit 1ns;
	timeprecision 1ns;

	// cycles allowed for dut_busy to change
	localparam int busy_timeout = 2000;
	localparam int reset_timeout = 100;

	logic clk;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	bnn_conv_pkg::mem_addr_t dut_sram_read_address;
	bnn_conv_pkg::mem_word_t sram_dut_read_data = '0;
	bnn_conv_pkg::mem_addr_t dut_wmem_read_address;
	bnn_conv_pkg::mem_word_t wmem_dut_read_data = '0;
	bnn_conv_pkg::mem_addr_t dut_sram_write_address;
	bnn_conv_pkg::mem_word_t dut_sram_write_data;
	logic dut_sram_write_enable;

	// input and weight sram models
	bnn_conv_pkg::mem_word_t in_mem [4096];
	bnn_conv_pkg::mem_word_t w_mem [4096];
	// read addresses as seen at the last rising edge
	bnn_conv_pkg::mem_addr_t sram_addr_q;
	bnn_conv_pkg::mem_addr_t wmem_addr_q;
	// expected and seen writes of the current job
	bnn_conv_pkg::mem_addr_t exp_addr [$];
	bnn_conv_pkg::mem_word_t exp_data [$];
	bnn_conv_pkg::mem_addr_t got_addr [$];
	bnn_conv_pkg::mem_word_t got_data [$];

	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;
	int runs = 0;
	logic timed_out = 1'b0;

	tb_clock_gen u_clock (
		.clk(clk),
		.reset_b(reset_b)
	);

	bnn_conv_top dut (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

	bind bnn_conv_top bnn_conv_assertions u_assertions (
		.clk(clk),
		.reset_b(reset_b),
		.dut_busy(dut_busy),
		.dut_sram_write_enable(dut_sram_write_enable),
		.dut_sram_write_data(dut_sram_write_data)
	);

	// address taken on the rising edge
	always @(posedge clk) begin
		sram_addr_q <= dut_sram_read_address;
		wmem_addr_q <= dut_wmem_read_address;
	end

	// data driven on the falling edge, so one cycle of read latency
	always @(negedge clk) begin
		sram_dut_read_data <= in_mem[sram_addr_q];
		wmem_dut_read_data <= w_mem[wmem_addr_q];
	end

	// every write is logged mid-cycle
	always @(negedge clk) begin
		if (reset_b && dut_sram_write_enable) begin
			$display("%0t ns write addr %h data %h", $time, dut_sram_write_address,
				dut_sram_write_data);
			got_addr.push_back(dut_sram_write_address);
			got_data.push_back(dut_sram_write_data);
		end
	end

	// engine must sit quiet for a few cycles
	task automatic check_idle(input int cycles);
		for (int k = 0; k < cycles; k++) begin
			@(negedge clk);
			checks += 2;
			assert (dut_busy == 1'b0) else begin
				value_errors++;
				$display("FAIL %0t ns dut_busy got %b expected 0", $time, dut_busy);
			end
			assert (dut_sram_write_enable == 1'b0) else begin
				value_errors++;
				$display("FAIL %0t ns dut_sram_write_enable got %b expected 0", $time,
					dut_sram_write_enable);
			end
		end
	endtask

	// bounded wait for dut_busy to reach a level
	task automatic wait_busy(input logic level);
		int k;
		k = 0;
		while (dut_busy !== level && k < busy_timeout) begin
			@(negedge clk);
			k++;
		end
		assert (dut_busy === level) else begin
			other_errors++;
			timed_out = 1'b1;
			$display("timeout, dut_busy did not become %b within %0d cycles", level,
				busy_timeout);
		end
	endtask

	// writes in order against the expected list
	task automatic compare_writes();
		int n;
		n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
		checks++;
		assert (got_addr.size() == exp_addr.size()) else begin
			value_errors++;
			$display("FAIL %0t ns write count got %0d expected %0d", $time,
				got_addr.size(), exp_addr.size());
		end
		for (int k = 0; k < n; k++) begin
			checks += 2;
			assert (got_addr[k] == exp_addr[k]) else begin
				value_errors++;
				$display("FAIL %0t ns dut_sram_write_address write %0d got %h expected %h",
					$time, k, got_addr[k], exp_addr[k]);
			end
			assert (got_data[k] == exp_data[k]) else begin
				value_errors++;
				$display("FAIL %0t ns dut_sram_write_data write %0d got %h expected %h",
					$time, k, got_data[k], exp_data[k]);
			end
		end
	endtask

	// one job plus an extra run pulse while busy that must be ignored
	task automatic run_job();
		got_addr.delete();
		got_data.delete();
		check_idle(4);
		dut_run = 1'b1;
		@(negedge clk);
		dut_run = 1'b0;
		wait_busy(1'b1);
		if (!timed_out) begin
			dut_run = 1'b1;
			@(negedge clk);
			dut_run = 1'b0;
			wait_busy(1'b0);
		end
		if (!timed_out)
			compare_writes();
		runs++;
	endtask

	initial begin : replay
		int fd;
		int n;
		int k;
		string line;
		byte cmd;
		bnn_conv_pkg::mem_addr_t addr;
		bnn_conv_pkg::mem_word_t data;
		logic pending;

		dut_run = 1'b0;
		pending = 1'b0;
		// fill marks every word with its own address
		for (int a = 0; a < 4096; a++) begin
			in_mem[a] = 16'hC000 | 16'(a);
			w_mem[a] = 16'hA000 | 16'(a);
		end
		// wait for reset release
		k = 0;
		while (reset_b !== 1'b1 && k < reset_timeout) begin
			@(negedge clk);
			k++;
		end
		assert (reset_b === 1'b1) else begin
			other_errors++;
			timed_out = 1'b1;
			$display("timeout, reset was never released");
		end
		fd = $fopen("bnn_conv_trace.txt", "r");
		assert (fd != 0) else begin
			other_errors++;
			$display("trace file bnn_conv_trace.txt could not be opened");
		end
		while (fd != 0 && !timed_out && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				cmd = line.getc(0);
				// any line other than an expected write closes the open job
				if (pending && cmd != "e") begin
					run_job();
					pending = 1'b0;
				end
				if (cmd == "r") begin
					exp_addr.delete();
					exp_data.delete();
					pending = 1'b1;
				end else begin
					n = $sscanf(line.substr(2, line.len() - 1), "%h %h", addr, data);
					assert (n == 2 && (cmd == "i" || cmd == "w" || cmd == "e")) else begin
						other_errors++;
						$display("trace line not understood: %s", line);
					end
					if (cmd == "i")
						in_mem[addr] = data;
					else if (cmd == "w")
						w_mem[addr] = data;
					else if (cmd == "e") begin
						exp_addr.push_back(addr);
						exp_data.push_back(data);
					end
				end
			end
		end
		if (pending && !timed_out)
			run_job();
		if (fd != 0)
			$fclose(fd);
		$display("runs %0d checks %0d value errors %0d other errors %0d", runs, checks,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- tb_clock_gen.sv
// testbench clock and power-on reset source, instantiated once by the convolution engine testbench
module tb_clock_gen (
	output logic clk,
	output logic reset_b
);
	timeunit 1ns;
	timeprecision 1ns;

	// 40 ns period
	localparam int half_period = 20;
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		reset_b = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_b = 1'b1;
	end

endmodule
